/* multi_level_cache_system.f */
+incdir+src
src/cache_pkg.sv
src/l1_cache.sv
src/l2_request_arbiter.sv
src/l2_cache.sv
src/multi_level_cache_system.sv
sim/tb_clock.sv
sim/cache_checker.sv
sim/tb_multi_level_cache_system.sv

/* run_sim.sh */
#!/bin/sh
# build and run the cache subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 \
	--top-module tb_multi_level_cache_system \
	-f multi_level_cache_system.f \
	-o sim_cache

./obj_dir/sim_cache 2>&1 | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi

echo "simulation log in sim.log"
exit 0

/* sim/cache_cases.txt */
# name port(i/d/b or -) op(r/w/reset) address wdata expected_rdata mem_requests
# address and data in hex, mem_requests in decimal; rdata is not checked on writes
cold_inst i r 000010 00000000 5a5a0010 1
cold_data d r 000021 00000000 5a5a0021 1
hit_inst i r 000010 00000000 5a5a0010 0
hit_data d r 000021 00000000 5a5a0021 0
inst_from_l2 i r 000021 00000000 5a5a0021 0
l1_conflict_cold i r 000030 00000000 5a5a0030 1
l1_conflict_back i r 000010 00000000 5a5a0010 0
write_hit d w 000021 deadbeef 00000000 0
read_after_write d r 000021 00000000 deadbeef 0
write_alloc d w 000033 cafef00d 00000000 1
read_l2_merged d r 000033 00000000 cafef00d 0
inst_sees_write i r 000033 00000000 cafef00d 0
dirty_victim_write d w 000045 12345678 00000000 1
evict_dirty d r 000105 00000000 5a5a0105 2
written_back d r 000045 00000000 12345678 1
both_cold b r 000077 00000000 5a5a0077 1
both_hit b r 000077 00000000 5a5a0077 0
reset - reset 000000 00000000 00000000 0
after_reset_data d r 000045 00000000 12345678 1
after_reset_inst i r 000010 00000000 5a5a0010 1
after_reset_hit i r 000010 00000000 5a5a0010 0

/* sim/tb_multi_level_cache_system.sv */
// testbench top for the two-level cache subsystem
// replays the cases file on both core ports against a memory model with varying latency

`timescale 1ns/1ps

module tb_multi_level_cache_system;

	import cache_pkg::*;

	localparam int CASE_CYCLES = 150;
	localparam int RESET_CYCLES = 8;

	logic  clock;
	logic  reset;
	logic  inst_req;
	addr_t inst_add;
	logic  inst_done;
	word_t inst_data;
	logic  data_req;
	logic  data_rw;
	addr_t data_add;
	word_t data_wdata;
	logic  data_done;
	word_t data_rdata;
	logic  mem_req;
	logic  mem_rw;
	addr_t mem_add;
	word_t mem_wdata;
	logic  mem_done;
	word_t mem_rdata;
	int    pass_count;
	int    fail_count;

	// case table, one entry per line of the cases file
	string case_name [$];
	string case_port [$];
	string case_op [$];
	addr_t case_add [$];
	word_t case_wdata [$];
	word_t case_rdata [$];
	int    case_mem [$];
	int    num_entries = 0;
	logic  cases_loaded = 1'b0;

	// external memory, only written words are stored
	word_t       mem_words [addr_t];
	logic [31:0] lcg_state = 32'haab36655;

	tb_clock #(
		.PERIOD_NS (10)
	) clk0 (
		.clock_o (clock)
	);

	multi_level_cache_system dut0 (
		.clock_i     (clock),
		.reset_i     (reset),
		.inst_req_i  (inst_req),
		.inst_add_i  (inst_add),
		.inst_done_o (inst_done),
		.inst_data_o (inst_data),
		.data_req_i  (data_req),
		.data_rw_i   (data_rw),
		.data_add_i  (data_add),
		.data_data_i (data_wdata),
		.data_done_o (data_done),
		.data_data_o (data_rdata),
		.mem_req_o   (mem_req),
		.mem_rw_o    (mem_rw),
		.mem_add_o   (mem_add),
		.mem_data_o  (mem_wdata),
		.mem_done_i  (mem_done),
		.mem_data_i  (mem_rdata)
	);

	cache_checker chk0 (
		.clock_i      (clock),
		.inst_done_i  (inst_done),
		.inst_data_i  (inst_data),
		.data_done_i  (data_done),
		.data_data_i  (data_rdata),
		.mem_req_i    (mem_req),
		.pass_count_o (pass_count),
		.fail_count_o (fail_count)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// untouched words follow the fill rule
	function automatic word_t mem_read(input addr_t a);
		if (mem_words.exists(a)) begin
			return mem_words[a];
		end
		return {8'h00, a} ^ 32'h5a5a0000;
	endfunction

	// ----------------------------------------------------------------------
	// external memory model
	// ----------------------------------------------------------------------
	initial begin : memory_model
		int    delay;
		logic  rw;
		addr_t a;
		word_t wd;
		mem_done = 1'b0;
		mem_rdata = '0;
		forever begin
			@(posedge clock);
			#1;
			if (mem_req) begin
				rw = mem_rw;
				a = mem_add;
				wd = mem_wdata;
				lcg_state = lcg_next(lcg_state);
				delay = 1 + int'((lcg_state >> 16) % 32'd8);
				repeat (delay) @(posedge clock);
				#1;
				if (rw) begin
					mem_words[a] = wd;
				end else begin
					mem_rdata = mem_read(a);
				end
				mem_done = 1'b1;
				@(posedge clock);
				#1;
				mem_done = 1'b0;
			end
		end
	end

	// ----------------------------------------------------------------------
	// stimulus helpers
	// ----------------------------------------------------------------------
	task automatic read_cases(output bit loaded);
		int    fd;
		int    n;
		string line;
		string name;
		string port;
		string op;
		addr_t a;
		word_t wd;
		word_t rd;
		int    mc;
		loaded = 1'b0;
		fd = $fopen("sim/cache_cases.txt", "r");
		if (fd != 0) begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 0 && line.getc(0) != "#") begin
					n = $sscanf(line, "%s %s %s %h %h %h %d", name, port, op, a, wd, rd, mc);
					if (n == 7) begin
						case_name.push_back(name);
						case_port.push_back(port);
						case_op.push_back(op);
						case_add.push_back(a);
						case_wdata.push_back(wd);
						case_rdata.push_back(rd);
						case_mem.push_back(mc);
					end
				end
			end
			$fclose(fd);
			num_entries = case_name.size();
			loaded = (num_entries > 0);
		end
	endtask

	task automatic apply_reset();
		@(posedge clock);
		#1;
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		reset = 1'b0;
	endtask

	task automatic run_case(input int i);
		bit use_inst;
		bit use_data;
		bit inst_seen;
		bit data_seen;
		int waited;
		use_inst = (case_port[i] == "i") || (case_port[i] == "b");
		use_data = (case_port[i] == "d") || (case_port[i] == "b");
		chk0.start_case(case_name[i], use_inst, use_data, case_op[i] == "w", case_rdata[i],
			case_mem[i]);

		@(posedge clock);
		#1;
		if (use_inst) begin
			inst_req = 1'b1;
			inst_add = case_add[i];
		end
		if (use_data) begin
			data_req = 1'b1;
			data_rw = (case_op[i] == "w");
			data_add = case_add[i];
			data_wdata = case_wdata[i];
		end

		inst_seen = !use_inst;
		data_seen = !use_data;
		waited = 0;
		while (!(inst_seen && data_seen) && waited < CASE_CYCLES) begin
			@(posedge clock);
			#1;
			waited++;
			// a port whose done came in the last cycle lets go now
			if (inst_seen) begin
				inst_req = 1'b0;
			end
			if (data_seen) begin
				data_req = 1'b0;
				data_rw = 1'b0;
			end
			if (inst_done) begin
				inst_seen = 1'b1;
			end
			if (data_done) begin
				data_seen = 1'b1;
			end
		end

		@(posedge clock);
		#1;
		inst_req = 1'b0;
		data_req = 1'b0;
		data_rw = 1'b0;
		chk0.finish_case();
	endtask

	// ----------------------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------------------
	initial begin
		bit loaded;
		reset = 1'b1;
		inst_req = 1'b0;
		inst_add = '0;
		data_req = 1'b0;
		data_rw = 1'b0;
		data_add = '0;
		data_wdata = '0;
		read_cases(loaded);
		if (!loaded) begin
			$display("could not read any case from sim/cache_cases.txt");
			$display("TESTBENCH FAILED");
			$finish;
		end else begin
			cases_loaded = 1'b1;
			apply_reset();
			for (int i = 0; i < num_entries; i++) begin
				if (case_op[i] == "reset") begin
					apply_reset();
				end else begin
					run_case(i);
				end
			end
			chk0.print_summary();
			if (fail_count == 0 && pass_count > 0) begin
				$display("TESTBENCH PASSED");
			end else begin
				$display("TESTBENCH FAILED");
			end
			$finish;
		end
	end

	// watchdog, scaled by the number of entries
	initial begin
		wait (cases_loaded);
		repeat (num_entries * 200 + RESET_CYCLES) @(posedge clock);
		$display("watchdog: the run did not finish in %0d cycles",
			num_entries * 200 + RESET_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* sim/cache_checker.sv */
// cache subsystem checker
// counts done pulses and memory requests per case and compares them with the case

`timescale 1ns/1ps

module cache_checker (
	input  logic             clock_i,
	input  logic             inst_done_i,
	input  cache_pkg::word_t inst_data_i,
	input  logic             data_done_i,
	input  cache_pkg::word_t data_data_i,
	input  logic             mem_req_i,
	output int               pass_count_o,
	output int               fail_count_o
);

	import cache_pkg::*;

	// running totals, only the sampling block writes these
	int    inst_dones = 0;
	int    data_dones = 0;
	int    mem_reqs = 0;
	logic  mem_req_prev = 1'b0;
	word_t inst_last = '0;
	word_t data_last = '0;

	// current case
	string cur_name = "";
	bit    want_inst = 1'b0;
	bit    want_data = 1'b0;
	bit    write_op = 1'b0;
	word_t exp_rdata = '0;
	int    exp_mem = 0;
	int    inst_base = 0;
	int    data_base = 0;
	int    mem_base = 0;

	int    pass_count = 0;
	int    fail_count = 0;

	assign pass_count_o = pass_count;
	assign fail_count_o = fail_count;

	// mid-cycle sampling, outputs are settled here
	always @(negedge clock_i) begin
		if (inst_done_i) begin
			inst_dones <= inst_dones + 1;
			inst_last <= inst_data_i;
		end
		if (data_done_i) begin
			data_dones <= data_dones + 1;
			data_last <= data_data_i;
		end
		if (mem_req_i && !mem_req_prev) begin
			mem_reqs <= mem_reqs + 1;
		end
		mem_req_prev <= mem_req_i;
	end

	task automatic start_case(input string name, input bit use_inst, input bit use_data,
		input bit is_write, input word_t rdata, input int mem_count);
		cur_name = name;
		want_inst = use_inst;
		want_data = use_data;
		write_op = is_write;
		exp_rdata = rdata;
		exp_mem = mem_count;
		inst_base = inst_dones;
		data_base = data_dones;
		mem_base = mem_reqs;
	endtask

	task automatic finish_case();
		int got_inst;
		int got_data;
		int got_mem;
		bit ok;
		got_inst = inst_dones - inst_base;
		got_data = data_dones - data_base;
		got_mem = mem_reqs - mem_base;
		ok = 1'b1;

		// instruction port, always a read
		if (want_inst && got_inst == 0) begin
			$display("%s: no done from the instruction port before the case time ran out",
				cur_name);
			ok = 1'b0;
		end else if (want_inst && inst_last != exp_rdata) begin
			$display("Fail %s expected %h actual %h", cur_name, exp_rdata, inst_last);
			ok = 1'b0;
		end
		if (got_inst > (want_inst ? 1 : 0)) begin
			$display("%s: unexpected done pulse on the instruction port", cur_name);
			ok = 1'b0;
		end

		// data port, read data only checked on reads
		if (want_data && got_data == 0) begin
			$display("%s: no done from the data port before the case time ran out", cur_name);
			ok = 1'b0;
		end else if (want_data && !write_op && data_last != exp_rdata) begin
			$display("Fail %s expected %h actual %h", cur_name, exp_rdata, data_last);
			ok = 1'b0;
		end
		if (got_data > (want_data ? 1 : 0)) begin
			$display("%s: unexpected done pulse on the data port", cur_name);
			ok = 1'b0;
		end

		if (got_mem != exp_mem) begin
			$display("Fail %s expected %0d memory requests actual %0d", cur_name, exp_mem,
				got_mem);
			ok = 1'b0;
		end

		if (ok) begin
			pass_count = pass_count + 1;
			$display("Pass %s", cur_name);
		end else begin
			fail_count = fail_count + 1;
		end
	endtask

	task automatic print_summary();
		$display("cases passed %0d, failed %0d", pass_count, fail_count);
	endtask

endmodule

/* sim/tb_clock.sv */
// testbench clock source
// free-running clock, starts low

`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS = 10
) (
	output logic clock_o
);

	initial begin
		clock_o = 1'b0;
		forever begin
			#(PERIOD_NS / 2) clock_o = ~clock_o;
		end
	end

endmodule

/* src/multi_level_cache_system.sv */
// two-level cache subsystem top
// split L1 instruction and data caches, arbiter, shared write-back L2

`timescale 1ns/1ps

module multi_level_cache_system (
	input  logic             clock_i,
	input  logic             reset_i,

	// core instruction references
	input  logic             inst_req_i,
	input  cache_pkg::addr_t inst_add_i,
	output logic             inst_done_o,
	output cache_pkg::word_t inst_data_o,

	// core data references
	input  logic             data_req_i,
	input  logic             data_rw_i,
	input  cache_pkg::addr_t data_add_i,
	input  cache_pkg::word_t data_data_i,
	output logic             data_done_o,
	output cache_pkg::word_t data_data_o,

	// external memory, word addressed
	output logic             mem_req_o,
	output logic             mem_rw_o,
	output cache_pkg::addr_t mem_add_o,
	output cache_pkg::word_t mem_data_o,
	input  logic             mem_done_i,
	input  cache_pkg::word_t mem_data_i
);

	import cache_pkg::*;

	// inst L1 <-> arbiter
	logic  inst_l2_req;
	addr_t inst_l2_add;
	logic  inst_l2_done;
	word_t inst_l2_data;

	// data L1 <-> arbiter
	logic  data_l2_req;
	logic  data_l2_rw;
	addr_t data_l2_add;
	word_t data_l2_wdata;
	logic  data_l2_done;
	word_t data_l2_rdata;

	// arbiter <-> L2
	logic  arb_req;
	logic  arb_rw;
	addr_t arb_add;
	word_t arb_wdata;
	logic  arb_done;
	word_t arb_rdata;

	// ----------------------------------------------------------------------
	// first level
	// ----------------------------------------------------------------------
	l1_cache #(
		.WRITABLE (1'b0)
	) inst_cache (
		.clock_i     (clock_i),
		.reset_i     (reset_i),
		.core_req_i  (inst_req_i),
		.core_rw_i   (1'b0),
		.core_add_i  (inst_add_i),
		.core_data_i ('0),
		.core_done_o (inst_done_o),
		.core_data_o (inst_data_o),
		.l2_req_o    (inst_l2_req),
		// read only, write path left open
		.l2_rw_o     (),
		.l2_add_o    (inst_l2_add),
		.l2_data_o   (),
		.l2_done_i   (inst_l2_done),
		.l2_data_i   (inst_l2_data)
	);

	l1_cache #(
		.WRITABLE (1'b1)
	) data_cache (
		.clock_i     (clock_i),
		.reset_i     (reset_i),
		.core_req_i  (data_req_i),
		.core_rw_i   (data_rw_i),
		.core_add_i  (data_add_i),
		.core_data_i (data_data_i),
		.core_done_o (data_done_o),
		.core_data_o (data_data_o),
		.l2_req_o    (data_l2_req),
		.l2_rw_o     (data_l2_rw),
		.l2_add_o    (data_l2_add),
		.l2_data_o   (data_l2_wdata),
		.l2_done_i   (data_l2_done),
		.l2_data_i   (data_l2_rdata)
	);

	// ----------------------------------------------------------------------
	// arbiter and second level
	// ----------------------------------------------------------------------
	l2_request_arbiter l2_arb (
		.clock_i     (clock_i),
		.reset_i     (reset_i),
		.inst_req_i  (inst_l2_req),
		.inst_add_i  (inst_l2_add),
		.inst_done_o (inst_l2_done),
		.inst_data_o (inst_l2_data),
		.data_req_i  (data_l2_req),
		.data_rw_i   (data_l2_rw),
		.data_add_i  (data_l2_add),
		.data_data_i (data_l2_wdata),
		.data_done_o (data_l2_done),
		.data_data_o (data_l2_rdata),
		.l2_req_o    (arb_req),
		.l2_rw_o     (arb_rw),
		.l2_add_o    (arb_add),
		.l2_data_o   (arb_wdata),
		.l2_done_i   (arb_done),
		.l2_data_i   (arb_rdata)
	);

	l2_cache l2_combined_cache (
		.clock_i    (clock_i),
		.reset_i    (reset_i),
		.req_i      (arb_req),
		.rw_i       (arb_rw),
		.add_i      (arb_add),
		.data_i     (arb_wdata),
		.done_o     (arb_done),
		.data_o     (arb_rdata),
		.mem_req_o  (mem_req_o),
		.mem_rw_o   (mem_rw_o),
		.mem_add_o  (mem_add_o),
		.mem_data_o (mem_data_o),
		.mem_done_i (mem_done_i),
		.mem_data_i (mem_data_i)
	);

endmodule

/* src/l2_cache.sv */
// direct-mapped write-back, write-allocate L2 cache
// dirty victims go out to memory before the missing word is fetched

`timescale 1ns/1ps
`include "cache_params.svh"

module l2_cache (
	input  logic             clock_i,
	input  logic             reset_i,

	// upper port from the arbiter
	input  logic             req_i,
	input  logic             rw_i,
	input  cache_pkg::addr_t add_i,
	input  cache_pkg::word_t data_i,
	output logic             done_o,
	output cache_pkg::word_t data_o,

	// external memory
	output logic             mem_req_o,
	output logic             mem_rw_o,
	output cache_pkg::addr_t mem_add_o,
	output cache_pkg::word_t mem_data_o,
	input  logic             mem_done_i,
	input  cache_pkg::word_t mem_data_i
);

	import cache_pkg::*;

	localparam int LINES = 1 << `L2_INDEX_BITS;

	l2_state_t state_q;
	logic      mem_req_q;
	logic      valid_q [LINES];
	logic      dirty_q [LINES];
	l2_tag_t   tag_q   [LINES];
	word_t     data_q  [LINES];
	word_t     rdata_q;

	l2_index_t index;
	l2_tag_t   tag;
	logic      hit;
	logic      fill;

	assign index = add_i[`L2_INDEX_BITS-1:0];
	assign tag = add_i[`CACHE_ADDR_BITS-1:`L2_INDEX_BITS];
	assign hit = valid_q[index] && (tag_q[index] == tag);

	// memory read returned for the requested word
	assign fill = (state_q == L2_FETCH) && mem_req_q && mem_done_i;

	// ----------------------------------------------------------------------
	// control
	// ----------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			state_q <= L2_IDLE;
			mem_req_q <= 1'b0;
			for (int i = 0; i < LINES; i++) begin
				valid_q[i] <= 1'b0;
				dirty_q[i] <= 1'b0;
			end
		end else begin
			case (state_q)
				L2_IDLE: begin
					if (req_i) begin
						state_q <= L2_LOOKUP;
					end
				end
				L2_LOOKUP: begin
					if (hit) begin
						state_q <= L2_RESPOND;
						if (rw_i) begin
							dirty_q[index] <= 1'b1;
						end
					end else if (valid_q[index] && dirty_q[index]) begin
						state_q <= L2_WRITE_BACK;
						mem_req_q <= 1'b1;
					end else begin
						state_q <= L2_FETCH;
						mem_req_q <= 1'b1;
					end
				end
				L2_WRITE_BACK: begin
					// drop req for a cycle so the fetch is a new request
					if (mem_done_i) begin
						state_q <= L2_FETCH;
						mem_req_q <= 1'b0;
						dirty_q[index] <= 1'b0;
					end
				end
				L2_FETCH: begin
					if (!mem_req_q) begin
						mem_req_q <= 1'b1;
					end else if (mem_done_i) begin
						state_q <= L2_RESPOND;
						mem_req_q <= 1'b0;
						valid_q[index] <= 1'b1;
						dirty_q[index] <= rw_i;
					end
				end
				L2_RESPOND: begin
					state_q <= L2_IDLE;
				end
				default: begin
					state_q <= L2_IDLE;
				end
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// tag and data arrays
	// ----------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (state_q == L2_LOOKUP && hit) begin
			rdata_q <= data_q[index];
			if (rw_i) begin
				data_q[index] <= data_i;
			end
		end
		if (fill) begin
			rdata_q <= mem_data_i;
			tag_q[index] <= tag;
			// write miss merges the new word over the fetched one
			data_q[index] <= rw_i ? data_i : mem_data_i;
		end
	end

	// outputs
	assign done_o = (state_q == L2_RESPOND);
	assign data_o = rdata_q;

	assign mem_req_o = mem_req_q;
	assign mem_rw_o = (state_q == L2_WRITE_BACK);
	// victim address while writing back, requested address otherwise
	assign mem_add_o = (state_q == L2_WRITE_BACK) ? {tag_q[index], index} : add_i;
	assign mem_data_o = data_q[index];

endmodule

/* src/l2_request_arbiter.sv */
// fixed-priority arbiter from the two L1 lower ports onto the L2 port
// data side wins a tie, grant is held until the L2 done

`timescale 1ns/1ps

module l2_request_arbiter (
	input  logic             clock_i,
	input  logic             reset_i,

	// instruction L1, read only
	input  logic             inst_req_i,
	input  cache_pkg::addr_t inst_add_i,
	output logic             inst_done_o,
	output cache_pkg::word_t inst_data_o,

	// data L1
	input  logic             data_req_i,
	input  logic             data_rw_i,
	input  cache_pkg::addr_t data_add_i,
	input  cache_pkg::word_t data_data_i,
	output logic             data_done_o,
	output cache_pkg::word_t data_data_o,

	// L2
	output logic             l2_req_o,
	output logic             l2_rw_o,
	output cache_pkg::addr_t l2_add_o,
	output cache_pkg::word_t l2_data_o,
	input  logic             l2_done_i,
	input  cache_pkg::word_t l2_data_i
);

	import cache_pkg::*;

	logic busy_q;
	logic owner_data_q;
	logic sel_data;

	// live choice when idle, stored owner while a transfer is open
	assign sel_data = busy_q ? owner_data_q : data_req_i;

	// forwarding adds no cycle
	assign l2_req_o = sel_data ? data_req_i : inst_req_i;
	assign l2_rw_o = sel_data && data_rw_i;
	assign l2_add_o = sel_data ? data_add_i : inst_add_i;
	assign l2_data_o = sel_data ? data_data_i : '0;

	// ----------------------------------------------------------------------
	// grant tracking
	// ----------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			busy_q <= 1'b0;
			owner_data_q <= 1'b0;
		end else if (busy_q) begin
			if (l2_done_i) begin
				busy_q <= 1'b0;
			end
		end else if (l2_req_o) begin
			busy_q <= 1'b1;
			owner_data_q <= sel_data;
		end
	end

	// done goes back to the owner only
	assign inst_done_o = l2_done_i && !sel_data;
	assign data_done_o = l2_done_i && sel_data;
	assign inst_data_o = l2_data_i;
	assign data_data_o = l2_data_i;

endmodule

/* src/l1_cache.sv */
// direct-mapped L1 cache with one-word lines
// read misses fill from L2, writes go through to L2 without allocation

`timescale 1ns/1ps
`include "cache_params.svh"

module l1_cache #(
	parameter bit WRITABLE = 1'b1
) (
	input  logic             clock_i,
	input  logic             reset_i,

	// core side
	input  logic             core_req_i,
	input  logic             core_rw_i,
	input  cache_pkg::addr_t core_add_i,
	input  cache_pkg::word_t core_data_i,
	output logic             core_done_o,
	output cache_pkg::word_t core_data_o,

	// L2 side
	output logic             l2_req_o,
	output logic             l2_rw_o,
	output cache_pkg::addr_t l2_add_o,
	output cache_pkg::word_t l2_data_o,
	input  logic             l2_done_i,
	input  cache_pkg::word_t l2_data_i
);

	import cache_pkg::*;

	localparam int LINES = 1 << `L1_INDEX_BITS;

	l1_state_t state_q;
	logic      valid_q [LINES];
	l1_tag_t   tag_q   [LINES];
	word_t     data_q  [LINES];
	word_t     rdata_q;

	l1_index_t index;
	l1_tag_t   tag;
	logic      hit;
	logic      is_write;

	// address split, request is held steady until done
	assign index = core_add_i[`L1_INDEX_BITS-1:0];
	assign tag = core_add_i[`CACHE_ADDR_BITS-1:`L1_INDEX_BITS];
	assign hit = valid_q[index] && (tag_q[index] == tag);

	// instruction side never writes
	assign is_write = WRITABLE && core_rw_i;

	// ----------------------------------------------------------------------
	// control
	// ----------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			state_q <= L1_IDLE;
			for (int i = 0; i < LINES; i++) begin
				valid_q[i] <= 1'b0;
			end
		end else begin
			case (state_q)
				L1_IDLE: begin
					if (core_req_i) begin
						state_q <= L1_LOOKUP;
					end
				end
				L1_LOOKUP: begin
					// writes always go down, read hits answer locally
					if (hit && !is_write) begin
						state_q <= L1_RESPOND;
					end else begin
						state_q <= L1_MISS_WAIT;
					end
				end
				L1_MISS_WAIT: begin
					if (l2_done_i) begin
						state_q <= L1_RESPOND;
						if (!is_write) begin
							valid_q[index] <= 1'b1;
						end
					end
				end
				L1_RESPOND: begin
					state_q <= L1_IDLE;
				end
				default: begin
					state_q <= L1_IDLE;
				end
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// tag and data arrays
	// ----------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (state_q == L1_LOOKUP && hit) begin
			rdata_q <= data_q[index];
		end
		if (state_q == L1_MISS_WAIT && l2_done_i) begin
			rdata_q <= l2_data_i;
			if (!is_write) begin
				// read miss fill
				tag_q[index] <= tag;
				data_q[index] <= l2_data_i;
			end else if (hit) begin
				// write hit keeps the line coherent with L2
				data_q[index] <= core_data_i;
			end
		end
	end

	// outputs
	assign core_done_o = (state_q == L1_RESPOND);
	assign core_data_o = rdata_q;

	assign l2_req_o = (state_q == L1_MISS_WAIT);
	assign l2_rw_o = is_write;
	assign l2_add_o = core_add_i;
	assign l2_data_o = core_data_i;

endmodule

/* src/cache_pkg.sv */
// cache subsystem types
// address, word, tag and index vectors plus the L1 and L2 FSM states

`include "cache_params.svh"

package cache_pkg;

	// ----------------------------------------------------------------------
	// address and data
	// ----------------------------------------------------------------------
	typedef logic [`CACHE_ADDR_BITS-1:0] addr_t;
	typedef logic [`CACHE_WORD_BITS-1:0] word_t;

	// L1 address split
	typedef logic [`L1_INDEX_BITS-1:0] l1_index_t;
	typedef logic [`CACHE_ADDR_BITS-`L1_INDEX_BITS-1:0] l1_tag_t;

	// L2 address split
	typedef logic [`L2_INDEX_BITS-1:0] l2_index_t;
	typedef logic [`CACHE_ADDR_BITS-`L2_INDEX_BITS-1:0] l2_tag_t;

	// ----------------------------------------------------------------------
	// state machines
	// ----------------------------------------------------------------------
	typedef enum logic [1:0] {
		L1_IDLE,
		L1_LOOKUP,
		L1_MISS_WAIT,
		L1_RESPOND
	} l1_state_t;

	typedef enum logic [2:0] {
		L2_IDLE,
		L2_LOOKUP,
		L2_WRITE_BACK,
		L2_FETCH,
		L2_RESPOND
	} l2_state_t;

endpackage

/* src/cache_params.svh */
// cache subsystem widths
// address, data word and per-level index sizes shared by the package and RTL

`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// external memory is word addressed
`define CACHE_ADDR_BITS 24

// one word per line at every level
`define CACHE_WORD_BITS 32

// ----------------------------------------------------------------------
// index widths
// ----------------------------------------------------------------------

// 16 lines per L1
`define L1_INDEX_BITS 4

// 64 lines in the shared L2
`define L2_INDEX_BITS 6

`endif
